//--- Bender.yml
package:
  name: write_buffer

export_include_dirs:
  - .

sources:
  - wb_pkg.sv
  - store_align.sv
  - wr_fifo.sv
  - mem_conflict_chk.sv
  - wb_ctrl.sv
  - write_buffer_top.sv
  - target: test
    files:
      - tb_write_buffer.sv

//--- mem_conflict_chk.sv
////////////////////
// load/store conflict check
// flags a load whose byte range overlaps any pending store
////////////////////

`include "wb_defines.svh"

module mem_conflict_chk (
  input  wb_pkg::ld_req_t      ld_req_i,
  input  wb_pkg::wb_entry_t    entries_i [`WB_DEPTH],
  input  logic [`WB_PTR_W-1:0] rd_ptr_i,
  input  logic [`WB_CNT_W-1:0] cnt_i,
  output logic                 conflict_o
);

  logic [`WB_ADDR_W-1:0] ld_end;
  logic [`WB_DEPTH-1:0]  occupied;
  logic [`WB_DEPTH-1:0]  overlap;

  // last byte touched by the load
  assign ld_end = ld_req_i.addr + {{(`WB_ADDR_W-4){1'b0}}, 4'd1 << ld_req_i.size} - 1'b1;

  for (genvar k = 0; k < `WB_DEPTH; k++) begin : g_slot
    localparam logic [`WB_PTR_W-1:0] SLOT = k;
    logic [`WB_PTR_W-1:0] age;

    // distance from the oldest entry, wraps mod depth
    assign age = SLOT - rd_ptr_i;

    // slot holds a pending store when it is younger than the count
    assign occupied[k] = ({{(`WB_CNT_W-`WB_PTR_W){1'b0}}, age} < cnt_i);

    // ranges overlap when each starts at or before the other ends
    assign overlap[k] = occupied[k] &&
                        (ld_req_i.addr <= entries_i[k].end_addr) &&
                        (entries_i[k].start_addr <= ld_end);
  end

  assign conflict_o = |overlap;

endmodule

//--- store_align.sv
////////////////////
// store alignment
// moves store bytes onto their lanes in the 8-byte line
// and computes the byte range of the store
////////////////////

`include "wb_defines.svh"

module store_align (
  input  wb_pkg::st_req_t   req_i,
  output wb_pkg::wb_entry_t entry_o
);
  import wb_pkg::*;

  logic [`WB_DATA_W-1:0] byte_mask;
  logic [`WB_DATA_W-1:0] masked_data;
  logic [5:0]            lane_shift;
  logic [`WB_ADDR_W-1:0] byte_cnt;

  // keep only the bytes that belong to the store
  always_comb begin
    case (req_i.size)
      SIZE_1B: byte_mask = 64'h0000_0000_0000_00ff;
      SIZE_2B: byte_mask = 64'h0000_0000_0000_ffff;
      SIZE_4B: byte_mask = 64'h0000_0000_ffff_ffff;
      // full line
      default: byte_mask = '1;
    endcase
  end

  assign masked_data = req_i.data & byte_mask;

  // byte offset within the line, in bits
  assign lane_shift = {req_i.addr[2:0], 3'b000};

  assign byte_cnt = {{(`WB_ADDR_W-4){1'b0}}, 4'd1 << req_i.size};

  always_comb begin
    // bytes shifted past lane 7 fall off here
    entry_o.data       = masked_data << lane_shift;
    entry_o.start_addr = req_i.addr;
    // end address stays exact even when the lanes are truncated
    entry_o.end_addr   = req_i.addr + byte_cnt - 1'b1;
    entry_o.size       = req_i.size;
  end

endmodule

//--- tb_write_buffer.sv
////////////////////
// store write buffer testbench
// random stores, loads and memory back-pressure
// checked every cycle against a queue model
////////////////////

`include "wb_defines.svh"

module tb_write_buffer;
  timeunit 1ns;
  timeprecision 1ps;
  import wb_pkg::*;

  localparam int NUM_RANDOM      = 2000;
  localparam int DIRECTED_CYCLES = 64;
  localparam int TIMEOUT_NS      = (NUM_RANDOM + DIRECTED_CYCLES + 2) * 20 + 1000;

  logic                 clk = 1'b0;
  logic                 reset_i;
  logic                 st_valid_i;
  st_req_t              st_req_i;
  logic                 ld_valid_i;
  ld_req_t              ld_req_i;
  logic                 mem_ready_i;
  logic                 mem_wr_o;
  wb_entry_t            mem_entry_o;
  logic                 st_stall_o;
  logic                 ld_stall_o;
  logic [`WB_CNT_W-1:0] cnt_o;

  logic [31:0] lcg_state = 32'h0519_41c5;
  wb_entry_t   model_q [$];
  string       phase;

  write_buffer_top UUT (
    .clk         (clk),
    .reset_i     (reset_i),
    .st_valid_i  (st_valid_i),
    .st_req_i    (st_req_i),
    .ld_valid_i  (ld_valid_i),
    .ld_req_i    (ld_req_i),
    .mem_ready_i (mem_ready_i),
    .mem_wr_o    (mem_wr_o),
    .mem_entry_o (mem_entry_o),
    .st_stall_o  (st_stall_o),
    .ld_stall_o  (ld_stall_o),
    .cnt_o       (cnt_o)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected entry, built byte by byte onto the lanes
  function automatic wb_entry_t align_model(input logic [31:0] addr, input logic [63:0] data,
                                            input size_e size);
    wb_entry_t e;
    int        nbytes;
    int        lane;
    nbytes = 1 << int'(size);
    e = '0;
    for (int i = 0; i < nbytes; i++) begin
      lane = int'(addr[2:0]) + i;
      if (lane < 8) begin
        e.data[lane*8 +: 8] = data[i*8 +: 8];
      end
    end
    e.start_addr = addr;
    e.end_addr   = addr + 32'(nbytes) - 32'd1;
    e.size       = size;
    return e;
  endfunction

  // load range against every store still held in the model
  function automatic logic overlap_model(input logic [31:0] ld_addr, input size_e ld_size);
    logic [31:0] ld_last;
    logic        hit;
    ld_last = ld_addr + (32'd1 << int'(ld_size)) - 32'd1;
    hit = 1'b0;
    foreach (model_q[i]) begin
      if (ld_addr <= model_q[i].end_addr && model_q[i].start_addr <= ld_last) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic check_value(input string name, input logic [129:0] expected,
                             input logic [129:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    logic exp_mem_wr;
    logic exp_st_stall;
    logic exp_ld_stall;
    exp_mem_wr   = mem_ready_i && (model_q.size() != 0);
    exp_st_stall = st_valid_i && (model_q.size() == `WB_DEPTH);
    exp_ld_stall = ld_valid_i && overlap_model(ld_req_i.addr, ld_req_i.size);
    check_value({phase, " cnt_o"}, 130'(model_q.size()), 130'(cnt_o));
    check_value({phase, " mem_wr_o"}, 130'(exp_mem_wr), 130'(mem_wr_o));
    check_value({phase, " st_stall_o"}, 130'(exp_st_stall), 130'(st_stall_o));
    check_value({phase, " ld_stall_o"}, 130'(exp_ld_stall), 130'(ld_stall_o));
    if (exp_mem_wr) begin
      check_value({phase, " mem_entry_o"}, model_q[0], mem_entry_o);
    end
  endtask

  // state as the DUT will hold it after the coming edge
  task automatic update_model();
    logic do_push;
    logic do_pop;
    do_push = st_valid_i && (model_q.size() < `WB_DEPTH);
    do_pop  = mem_ready_i && (model_q.size() != 0);
    if (do_pop) begin
      void'(model_q.pop_front());
    end
    if (do_push) begin
      model_q.push_back(align_model(st_req_i.addr, st_req_i.data, st_req_i.size));
    end
  endtask

  task automatic drive_cycle(input logic st_v, input logic [31:0] st_addr, input size_e st_size,
                             input logic [63:0] st_data, input logic ld_v,
                             input logic [31:0] ld_addr, input size_e ld_size,
                             input logic mem_rdy);
    @(posedge clk);
    st_valid_i    <= st_v;
    st_req_i.addr <= st_addr;
    st_req_i.size <= st_size;
    st_req_i.data <= st_data;
    ld_valid_i    <= ld_v;
    ld_req_i.addr <= ld_addr;
    ld_req_i.size <= ld_size;
    mem_ready_i   <= mem_rdy;
    // outputs settle well before the falling edge
    @(negedge clk);
    check_outputs();
    update_model();
  endtask

  task automatic store_cycle(input logic [31:0] addr, input size_e size, input logic [63:0] data,
                             input logic mem_rdy);
    drive_cycle(1'b1, addr, size, data, 1'b0, 32'h0, SIZE_1B, mem_rdy);
  endtask

  task automatic idle_cycle(input logic mem_rdy);
    drive_cycle(1'b0, 32'h0, SIZE_1B, 64'h0, 1'b0, 32'h0, SIZE_1B, mem_rdy);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the DUT stopped making progress", TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  end

  initial begin
    logic [31:0] r_ctl;
    logic [31:0] r_d0;
    logic [31:0] r_d1;
    reset_i     = 1'b1;
    // a store, an overlapping load and a ready memory held through reset
    st_valid_i    = 1'b1;
    st_req_i      = '0;
    st_req_i.addr = 32'h0000_1003;
    st_req_i.data = 64'h0000_0000_0000_9e37;
    st_req_i.size = SIZE_2B;
    ld_valid_i    = 1'b1;
    ld_req_i      = '0;
    ld_req_i.addr = 32'h0000_1004;
    ld_req_i.size = SIZE_1B;
    mem_ready_i   = 1'b1;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check_value("reset cnt_o", 130'(0), 130'(cnt_o));
    check_value("reset mem_wr_o", 130'(0), 130'(mem_wr_o));
    check_value("reset st_stall_o", 130'(0), 130'(st_stall_o));
    check_value("reset ld_stall_o", 130'(0), 130'(ld_stall_o));
    // the held store is taken on the first edge out of reset
    update_model();

    // line-crossing stores lose their upper bytes
    phase = "align";
    store_cycle(32'h0000_1006, SIZE_8B, 64'h1122_3344_5566_7788, 1'b1);
    store_cycle(32'h0000_1017, SIZE_2B, 64'h0000_0000_0000_a5c3, 1'b1);
    store_cycle(32'h0000_1021, SIZE_4B, 64'hdead_beef_cafe_f00d, 1'b1);
    repeat (3) idle_cycle(1'b1);

    // six stores into a stalled memory, the last two must vanish
    phase = "full";
    for (int i = 0; i < 6; i++) begin
      store_cycle(32'h0000_1000 + 32'(i * 8), SIZE_4B, 64'h0bad_0000 + 64'(i), 1'b0);
    end
    check_value("full cnt_o", 130'(4), 130'(cnt_o));
    check_value("full st_stall_o", 130'(1), 130'(st_stall_o));
    repeat (6) idle_cycle(1'b1);

    phase = "push_pop";
    for (int i = 0; i < 4; i++) begin
      store_cycle(32'h0000_1040 + 32'(i * 8), SIZE_8B, 64'h7700_0000 + 64'(i), 1'b0);
    end
    store_cycle(32'h0000_1080, SIZE_8B, 64'h7700_00aa, 1'b1);
    store_cycle(32'h0000_1088, SIZE_8B, 64'h7700_00bb, 1'b0);
    check_value("push_pop cnt_o after pop", 130'(3), 130'(cnt_o));
    idle_cycle(1'b0);
    check_value("push_pop cnt_o after store", 130'(4), 130'(cnt_o));
    repeat (5) idle_cycle(1'b1);

    // small address window so loads hit pending stores often
    phase = "random";
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r_ctl = lcg_next();
      r_d0  = lcg_next();
      r_d1  = lcg_next();
      drive_cycle(r_ctl[31] | r_ctl[30], 32'h0000_1000 + 32'(r_ctl[21:16]),
                  size_e'(r_ctl[25:24]), {r_d0, r_d1}, r_ctl[29],
                  32'h0000_1000 + 32'(r_ctl[15:10]), size_e'(r_ctl[23:22]),
                  r_ctl[28] & (r_ctl[27] | r_ctl[26]));
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- wb_ctrl.sv
////////////////////
// write buffer control
// push, pop, memory write strobe and the stall outputs
////////////////////

module wb_ctrl (
  input  logic st_valid_i,
  input  logic ld_valid_i,
  input  logic mem_ready_i,
  input  logic empty_i,
  input  logic full_i,
  input  logic conflict_i,
  output logic wr_o,
  output logic rd_o,
  output logic mem_wr_o,
  output logic st_stall_o,
  output logic ld_stall_o
);

  // store taken only while there is room
  // a pop in the same cycle does not free a slot for it
  assign wr_o = st_valid_i & ~full_i;

  // drain the oldest entry whenever memory accepts
  assign rd_o = mem_ready_i & ~empty_i;

  // the drained entry goes out on the same edge it is popped
  assign mem_wr_o = rd_o;

  // hold the pipeline store until a slot frees up
  assign st_stall_o = st_valid_i & full_i;

  // any overlap with a pending store holds the load,
  // including the entry leaving this cycle
  assign ld_stall_o = ld_valid_i & conflict_i;

endmodule

//--- wb_defines.svh
////////////////////
// store write buffer widths and depth
// shared by the package and the datapath blocks
////////////////////

`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// address and data lane widths
`define WB_ADDR_W 32
`define WB_DATA_W 64

// buffer depth, pointer and count widths
// count needs one more bit than the pointer to hold a full buffer
`define WB_DEPTH  4
`define WB_PTR_W  2
`define WB_CNT_W  3

`endif

//--- wb_pkg.sv
////////////////////
// store write buffer types
// size code, pipeline requests and the buffer entry
////////////////////

`include "wb_defines.svh"

package wb_pkg;

  // access size, byte count is 1 << code
  typedef enum logic [1:0] {SIZE_1B, SIZE_2B, SIZE_4B, SIZE_8B} size_e;

  // store from the pipeline, data valid in the low bytes
  typedef struct packed {
    logic [`WB_ADDR_W-1:0] addr;
    logic [`WB_DATA_W-1:0] data;
    size_e                 size;
  } st_req_t;

  typedef struct packed {
    logic [`WB_ADDR_W-1:0] addr;
    size_e                 size;
  } ld_req_t;

  // 130 bit entry, data occupies the low 64 bits
  // then start address, end address and size at the top
  typedef struct packed {
    size_e                 size;
    logic [`WB_ADDR_W-1:0] end_addr;
    logic [`WB_ADDR_W-1:0] start_addr;
    logic [`WB_DATA_W-1:0] data;
  } wb_entry_t;

endpackage

//--- wr_fifo.sv
////////////////////
// write buffer storage
// 4-entry FIFO of store entries with count, empty and full,
// all slots and the read pointer visible to the conflict check
////////////////////

`include "wb_defines.svh"

module wr_fifo (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 wr_i,
  input  logic                 rd_i,
  input  wb_pkg::wb_entry_t    wr_data_i,
  output wb_pkg::wb_entry_t    rd_data_o,
  output wb_pkg::wb_entry_t    entries_o [`WB_DEPTH],
  output logic [`WB_PTR_W-1:0] rd_ptr_o,
  output logic [`WB_CNT_W-1:0] cnt_o,
  output logic                 empty_o,
  output logic                 full_o
);
  import wb_pkg::*;

  wb_entry_t            mem_q [`WB_DEPTH];
  logic [`WB_PTR_W-1:0] rd_ptr_q;
  logic [`WB_PTR_W-1:0] wr_ptr_q;
  logic [`WB_CNT_W-1:0] cnt_q;

  // pointers wrap naturally at the depth
  // wr_i and rd_i arrive already qualified by full and empty
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count alone
      case ({wr_i, rd_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  // oldest entry
  assign rd_data_o = mem_q[rd_ptr_q];

  assign entries_o = mem_q;
  assign rd_ptr_o  = rd_ptr_q;
  assign cnt_o     = cnt_q;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == `WB_DEPTH);

endmodule

//--- write_buffer_top.f
+incdir+.
wb_pkg.sv
store_align.sv
wr_fifo.sv
mem_conflict_chk.sv
wb_ctrl.sv
write_buffer_top.sv
tb_write_buffer.sv

//--- write_buffer_top.sv
////////////////////
// store write buffer top
// align, buffer and drain stores, stall conflicting loads
////////////////////

`include "wb_defines.svh"

module write_buffer_top (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 st_valid_i,
  input  wb_pkg::st_req_t      st_req_i,
  input  logic                 ld_valid_i,
  input  wb_pkg::ld_req_t      ld_req_i,
  input  logic                 mem_ready_i,
  output logic                 mem_wr_o,
  output wb_pkg::wb_entry_t    mem_entry_o,
  output logic                 st_stall_o,
  output logic                 ld_stall_o,
  output logic [`WB_CNT_W-1:0] cnt_o
);
  import wb_pkg::*;

  wb_entry_t            st_entry;
  wb_entry_t            entries [`WB_DEPTH];
  logic [`WB_PTR_W-1:0] rd_ptr;
  logic                 fifo_wr;
  logic                 fifo_rd;
  logic                 empty;
  logic                 full;
  logic                 conflict;

  store_align u_store_align (
    .req_i   (st_req_i),
    .entry_o (st_entry)
  );

  // oldest entry doubles as the memory write payload
  wr_fifo u_wr_fifo (
    .clk       (clk),
    .reset_i   (reset_i),
    .wr_i      (fifo_wr),
    .rd_i      (fifo_rd),
    .wr_data_i (st_entry),
    .rd_data_o (mem_entry_o),
    .entries_o (entries),
    .rd_ptr_o  (rd_ptr),
    .cnt_o     (cnt_o),
    .empty_o   (empty),
    .full_o    (full)
  );

  mem_conflict_chk u_mem_conflict_chk (
    .ld_req_i   (ld_req_i),
    .entries_i  (entries),
    .rd_ptr_i   (rd_ptr),
    .cnt_i      (cnt_o),
    .conflict_o (conflict)
  );

  wb_ctrl u_wb_ctrl (
    .st_valid_i  (st_valid_i),
    .ld_valid_i  (ld_valid_i),
    .mem_ready_i (mem_ready_i),
    .empty_i     (empty),
    .full_i      (full),
    .conflict_i  (conflict),
    .wr_o        (fifo_wr),
    .rd_o        (fifo_rd),
    .mem_wr_o    (mem_wr_o),
    .st_stall_o  (st_stall_o),
    .ld_stall_o  (ld_stall_o)
  );

endmodule
